// File: ceres_pkg.sv
package ceres_pkg;

  // ==================================================
  // Bus widths
  // ==================================================
  localparam int unsigned data_w = 32;
  localparam int unsigned addr_w = 32;
  // One strobe per data byte
  localparam int unsigned strb_w = data_w / 8;

  // ==================================================
  // Memory map
  // ==================================================
  // Upper nibble selects CLINT and peripheral window
  localparam logic [addr_w-1:0] region_mask      = 32'hF000_0000;
  // Top bit alone selects main RAM
  localparam logic [addr_w-1:0] ram_mask         = 32'h8000_0000;
  localparam logic [addr_w-1:0] mmap_ram_base    = 32'h8000_0000;
  localparam logic [addr_w-1:0] mmap_clint_base  = 32'h3000_0000;
  localparam logic [addr_w-1:0] mmap_periph_base = 32'h2000_0000;

  // Main RAM geometry and response delay
  localparam int unsigned ram_depth_words = 1024;
  localparam int unsigned ram_addr_w      = $clog2(ram_depth_words);
  localparam int unsigned ram_latency     = 4;
  // Counter wide enough to reach ram_latency
  localparam int unsigned ram_cnt_w       = $clog2(ram_latency + 1);

  // GPIO slot in the 4 KB peripheral window
  localparam logic [3:0]  gpio_slot    = 4'd4;
  localparam int unsigned gpio_w       = 32;
  // Register offsets inside the slot
  localparam logic [3:0]  gpio_out_off = 4'h0;
  localparam logic [3:0]  gpio_oe_off  = 4'h4;
  localparam logic [3:0]  gpio_in_off  = 4'h8;

  // CLINT offsets, low word of each 64-bit register
  localparam logic [15:0] clint_msip_off     = 16'h0000;
  localparam logic [15:0] clint_mtimecmp_off = 16'h4000;
  localparam logic [15:0] clint_mtime_off    = 16'hBFF8;

  // ==================================================
  // Decoded region of the current request
  // ==================================================
  typedef enum logic [1:0] {
    region_none,
    region_ram,
    region_clint,
    region_periph
  } region_e;

endpackage

// File: ceres_bus_decoder.sv
`timescale 1ns/1ps

module ceres_bus_decoder (
  // Request from the core side
  input  logic                         req_valid_i,
  input  logic [ceres_pkg::addr_w-1:0] req_addr_i,

  // Slave responses
  input  logic                         ram_rsp_valid_i,
  input  logic [ceres_pkg::data_w-1:0] ram_rdata_i,
  input  logic [ceres_pkg::data_w-1:0] clint_rdata_i,
  input  logic [ceres_pkg::data_w-1:0] gpio_rdata_i,

  // Slave selects
  output logic                         ram_sel_o,
  output logic                         clint_sel_o,
  output logic                         gpio_sel_o,

  // Response back to the core side
  output logic                         rsp_valid_o,
  output logic [ceres_pkg::data_w-1:0] rsp_rdata_o
);
  import ceres_pkg::*;

  region_e    region;
  logic [3:0] slot;

  // 4 KB peripheral slot index
  assign slot = req_addr_i[15:12];

  // ==================================================
  // Region classification
  // ==================================================
  // Priority order RAM, CLINT, peripheral window
  always_comb begin
    region = region_none;
    if (req_valid_i) begin
      if ((req_addr_i & ram_mask) == mmap_ram_base) begin
        region = region_ram;
      end else if ((req_addr_i & region_mask) == mmap_clint_base) begin
        region = region_clint;
      end else if ((req_addr_i & region_mask) == mmap_periph_base) begin
        region = region_periph;
      end
    end
  end

  // Select levels held for the whole request
  assign ram_sel_o   = (region == region_ram);
  assign clint_sel_o = (region == region_clint);
  // Only place where the slot is checked
  assign gpio_sel_o  = (region == region_periph) && (slot == gpio_slot);

  // ==================================================
  // Response multiplexer
  // ==================================================
  always_comb begin
    rsp_valid_o = 1'b0;
    rsp_rdata_o = '0;
    case (region)
      region_ram: begin
        // RAM answers after its latency counter
        rsp_valid_o = ram_rsp_valid_i;
        if (ram_rsp_valid_i) begin
          rsp_rdata_o = ram_rdata_i;
        end
      end
      region_clint: begin
        // Same-cycle answer
        rsp_valid_o = 1'b1;
        rsp_rdata_o = clint_rdata_i;
      end
      region_periph: begin
        // Empty slots answer at once with zero
        rsp_valid_o = 1'b1;
        if (gpio_sel_o) begin
          rsp_rdata_o = gpio_rdata_i;
        end
      end
      default: begin
        // Unmapped address, request just hangs
        rsp_valid_o = 1'b0;
      end
    endcase
  end

endmodule

// File: ceres_ram.sv
`timescale 1ns/1ps

module ceres_ram (
  input  logic                         clk_i,
  input  logic                         rst_ni,

  // Request fields, valid while sel_i is high
  input  logic                         sel_i,
  input  logic                         we_i,
  input  logic [ceres_pkg::addr_w-1:0] addr_i,
  input  logic [ceres_pkg::data_w-1:0] wdata_i,
  input  logic [ceres_pkg::strb_w-1:0] strb_i,

  // Response
  output logic [ceres_pkg::data_w-1:0] rdata_o,
  output logic                         rsp_valid_o
);
  import ceres_pkg::*;

  // Word storage
  logic [data_w-1:0]     mem_q [ram_depth_words];
  logic [ram_addr_w-1:0] word_idx;
  logic [data_w-1:0]     rdata_q;
  // Cycles since the first cycle of sel_i
  logic [ram_cnt_w-1:0]  cnt_q;
  logic                  done;

  // Word index from byte address
  assign word_idx = addr_i[ram_addr_w+1:2];

  // Response cycle once the counter reaches the latency
  assign done = sel_i && (cnt_q == ram_cnt_w'(ram_latency));

  // ==================================================
  // Latency counter
  // ==================================================
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (!sel_i || done) begin
      // Restart so the next request waits the full latency
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // Registered read port
  // Address is stable long before the response cycle
  always_ff @(posedge clk_i) begin
    if (sel_i) begin
      rdata_q <= mem_q[word_idx];
    end
  end

  // ==================================================
  // Byte-strobed write
  // ==================================================
  // Takes effect at the edge closing the response cycle
  always_ff @(posedge clk_i) begin
    if (done && we_i) begin
      for (int b = 0; b < strb_w; b++) begin
        if (strb_i[b]) begin
          mem_q[word_idx][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  assign rdata_o     = rdata_q;
  assign rsp_valid_o = done;

endmodule

// File: ceres_clint.sv
`timescale 1ns/1ps

module ceres_clint (
  input  logic                         clk_i,
  input  logic                         rst_ni,

  // Register access, answered in the same cycle
  input  logic                         sel_i,
  input  logic                         we_i,
  input  logic [ceres_pkg::addr_w-1:0] addr_i,
  input  logic [ceres_pkg::data_w-1:0] wdata_i,
  output logic [ceres_pkg::data_w-1:0] rdata_o,

  // Interrupt lines to the core
  output logic                         timer_irq_o,
  output logic                         sw_irq_o
);
  import ceres_pkg::*;

  logic [63:0] mtime_q;
  logic [63:0] mtime_d;
  logic [63:0] mtimecmp_q;
  logic        msip_q;
  logic [15:0] offset;
  logic        wr_en;

  // Offset inside the CLINT region
  assign offset = addr_i[15:0];
  assign wr_en  = sel_i && we_i;

  // ==================================================
  // Free-running mtime
  // ==================================================
  // Written half replaces the incremented value
  always_comb begin
    mtime_d = mtime_q + 64'd1;
    if (wr_en && (offset == clint_mtime_off)) begin
      mtime_d[31:0] = wdata_i;
    end
    if (wr_en && (offset == clint_mtime_off + 16'd4)) begin
      mtime_d[63:32] = wdata_i;
    end
  end

  // ==================================================
  // Register file
  // ==================================================
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mtime_q    <= '0;
      // All ones keeps the timer interrupt quiet
      mtimecmp_q <= '1;
      msip_q     <= 1'b0;
    end else begin
      mtime_q <= mtime_d;
      if (wr_en) begin
        case (offset)
          clint_msip_off:             msip_q <= wdata_i[0];
          clint_mtimecmp_off:         mtimecmp_q[31:0] <= wdata_i;
          clint_mtimecmp_off + 16'd4: mtimecmp_q[63:32] <= wdata_i;
          // Unknown offsets drop the write
          default: ;
        endcase
      end
    end
  end

  // Read mux
  always_comb begin
    case (offset)
      clint_msip_off:             rdata_o = {{(data_w-1){1'b0}}, msip_q};
      clint_mtimecmp_off:         rdata_o = mtimecmp_q[31:0];
      clint_mtimecmp_off + 16'd4: rdata_o = mtimecmp_q[63:32];
      clint_mtime_off:            rdata_o = mtime_q[31:0];
      clint_mtime_off + 16'd4:    rdata_o = mtime_q[63:32];
      default:                    rdata_o = '0;
    endcase
  end

  // ==================================================
  // Comparator beside the registers
  // ==================================================
  // Level interrupt while mtime at or above mtimecmp
  assign timer_irq_o = (mtime_q >= mtimecmp_q);
  assign sw_irq_o    = msip_q;

endmodule

// File: ceres_gpio.sv
`timescale 1ns/1ps

module ceres_gpio (
  input  logic                         clk_i,
  input  logic                         rst_ni,

  // Register access, slot already checked by the decoder
  input  logic                         sel_i,
  input  logic                         we_i,
  input  logic [ceres_pkg::addr_w-1:0] addr_i,
  input  logic [ceres_pkg::data_w-1:0] wdata_i,
  input  logic [ceres_pkg::strb_w-1:0] strb_i,
  output logic [ceres_pkg::data_w-1:0] rdata_o,

  // Pins
  input  logic [ceres_pkg::gpio_w-1:0] gpio_i,
  output logic [ceres_pkg::gpio_w-1:0] gpio_o,
  output logic [ceres_pkg::gpio_w-1:0] gpio_oe_o
);
  import ceres_pkg::*;

  logic [gpio_w-1:0] out_q;
  logic [gpio_w-1:0] oe_q;
  // Two-flop synchronizer ahead of the input register
  logic [gpio_w-1:0] sync1_q;
  logic [gpio_w-1:0] sync2_q;
  logic [gpio_w-1:0] in_q;
  logic [3:0]        offset;
  logic              wr_en;

  // Word offset from address bits 3 to 2
  assign offset = {addr_i[3:2], 2'b00};
  assign wr_en  = sel_i && we_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_q   <= '0;
      oe_q    <= '0;
      sync1_q <= '0;
      sync2_q <= '0;
      in_q    <= '0;
    end else begin
      sync1_q <= gpio_i;
      sync2_q <= sync1_q;
      in_q    <= sync2_q;
      // Byte-strobed writes, input register is read-only
      if (wr_en) begin
        for (int b = 0; b < strb_w; b++) begin
          if (strb_i[b] && (offset == gpio_out_off)) begin
            out_q[8*b +: 8] <= wdata_i[8*b +: 8];
          end
          if (strb_i[b] && (offset == gpio_oe_off)) begin
            oe_q[8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end
    end
  end

  // Read mux, fourth word reads zero
  always_comb begin
    case (offset)
      gpio_out_off: rdata_o = out_q;
      gpio_oe_off:  rdata_o = oe_q;
      gpio_in_off:  rdata_o = in_q;
      default:      rdata_o = '0;
    endcase
  end

  // Pin drivers straight from the registers
  assign gpio_o    = out_q;
  assign gpio_oe_o = oe_q;

endmodule

// File: ceres_fabric_top.sv
`timescale 1ns/1ps

module ceres_fabric_top (
  input  logic                         clk_i,
  input  logic                         rst_ni,

  // Core request, held until rsp_valid_o
  input  logic                         req_valid_i,
  input  logic [ceres_pkg::addr_w-1:0] req_addr_i,
  input  logic                         req_we_i,
  input  logic [ceres_pkg::data_w-1:0] req_wdata_i,
  input  logic [ceres_pkg::strb_w-1:0] req_strb_i,

  // Response
  output logic                         rsp_valid_o,
  output logic [ceres_pkg::data_w-1:0] rsp_rdata_o,

  // GPIO pins
  input  logic [ceres_pkg::gpio_w-1:0] gpio_i,
  output logic [ceres_pkg::gpio_w-1:0] gpio_o,
  output logic [ceres_pkg::gpio_w-1:0] gpio_oe_o,

  // Interrupts
  output logic                         timer_irq_o,
  output logic                         sw_irq_o
);
  import ceres_pkg::*;

  // Selects from the decoder
  logic              ram_sel;
  logic              clint_sel;
  logic              gpio_sel;
  // Slave responses
  logic              ram_rsp_valid;
  logic [data_w-1:0] ram_rdata;
  logic [data_w-1:0] clint_rdata;
  logic [data_w-1:0] gpio_rdata;

  ceres_bus_decoder i_decoder (
    .req_valid_i     (req_valid_i),
    .req_addr_i      (req_addr_i),
    .ram_rsp_valid_i (ram_rsp_valid),
    .ram_rdata_i     (ram_rdata),
    .clint_rdata_i   (clint_rdata),
    .gpio_rdata_i    (gpio_rdata),
    .ram_sel_o       (ram_sel),
    .clint_sel_o     (clint_sel),
    .gpio_sel_o      (gpio_sel),
    .rsp_valid_o     (rsp_valid_o),
    .rsp_rdata_o     (rsp_rdata_o)
  );

  ceres_ram i_ram (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .sel_i       (ram_sel),
    .we_i        (req_we_i),
    .addr_i      (req_addr_i),
    .wdata_i     (req_wdata_i),
    .strb_i      (req_strb_i),
    .rdata_o     (ram_rdata),
    .rsp_valid_o (ram_rsp_valid)
  );

  ceres_clint i_clint (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .sel_i       (clint_sel),
    .we_i        (req_we_i),
    .addr_i      (req_addr_i),
    .wdata_i     (req_wdata_i),
    .rdata_o     (clint_rdata),
    .timer_irq_o (timer_irq_o),
    .sw_irq_o    (sw_irq_o)
  );

  ceres_gpio i_gpio (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .sel_i     (gpio_sel),
    .we_i      (req_we_i),
    .addr_i    (req_addr_i),
    .wdata_i   (req_wdata_i),
    .strb_i    (req_strb_i),
    .rdata_o   (gpio_rdata),
    .gpio_i    (gpio_i),
    .gpio_o    (gpio_o),
    .gpio_oe_o (gpio_oe_o)
  );

endmodule

// File: ceres_fabric_properties.sv
`timescale 1ns/1ps

module ceres_fabric_properties (
  input logic                         clk_i,
  input logic                         rst_ni,
  input logic                         req_valid_i,
  input logic [ceres_pkg::addr_w-1:0] req_addr_i,
  input logic                         rsp_valid_o,
  input logic                         timer_irq_o,
  input logic                         sw_irq_o
);
  import ceres_pkg::*;

  // Failed assertions, summed into the final count
  int   prop_errors = 0;
  logic unmapped;

  // Outside RAM, CLINT and peripheral window
  assign unmapped = ((req_addr_i & ram_mask) != mmap_ram_base)
                 && ((req_addr_i & region_mask) != mmap_clint_base)
                 && ((req_addr_i & region_mask) != mmap_periph_base);

  // Response only while a request is held
  rsp_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_valid_o |-> req_valid_i)
    else begin
      prop_errors++;
      $error("rsp_valid_o high without req_valid_i");
    end

  // Interrupts quiet right after reset release
  irq_quiet_after_reset: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> !timer_irq_o && !sw_irq_o)
    else begin
      prop_errors++;
      $error("interrupt active in the first cycle after reset");
    end

  // Unmapped request never answered
  no_rsp_unmapped: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_valid_i && unmapped |-> !rsp_valid_o)
    else begin
      prop_errors++;
      $error("response to an unmapped address");
    end

endmodule

bind ceres_fabric_top ceres_fabric_properties i_props (.*);

// File: tb_ceres_fabric.sv
`timescale 1ns/1ps

module tb_ceres_fabric;
  import ceres_pkg::*;

  logic              clk_i;
  logic              rst_ni;
  logic              req_valid_i;
  logic [addr_w-1:0] req_addr_i;
  logic              req_we_i;
  logic [data_w-1:0] req_wdata_i;
  logic [strb_w-1:0] req_strb_i;
  logic              rsp_valid_o;
  logic [data_w-1:0] rsp_rdata_o;
  logic [gpio_w-1:0] gpio_i;
  logic [gpio_w-1:0] gpio_o;
  logic [gpio_w-1:0] gpio_oe_o;
  logic              timer_irq_o;
  logic              sw_irq_o;

  // Expected RAM words, indexed like the RAM
  logic [31:0] ram_sb [1024];
  logic [31:0] last_mtime = '0;
  int          errors = 0;
  int          seed = 14764;
  // Pattern line fields
  int          fd;
  int          fields;
  string       line;
  byte         op;
  int          mode;
  logic [31:0] addr;
  logic [31:0] data;
  logic [3:0]  strb;
  logic [31:0] exp;

  ceres_fabric_top i_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  task automatic check_value(input string name, input logic [31:0] expv, input logic [31:0] got);
    assert (got === expv) else begin
      errors++;
      $display("** Error at %0t ns: %s expected %h, got %h", $time, name, expv, got);
    end
  endtask

  // ==================================================
  // Bus access tasks
  // ==================================================
  // Held request, lat counts cycles before rsp_valid_o
  task automatic bus_access(input logic [31:0] a, input logic we, input logic [31:0] wd,
                            input logic [3:0] st, output logic [31:0] rd, output int lat);
    @(posedge clk_i);
    req_valid_i <= 1'b1;
    req_addr_i  <= a;
    req_we_i    <= we;
    req_wdata_i <= wd;
    req_strb_i  <= st;
    lat = 0;
    @(negedge clk_i);
    while (!rsp_valid_o && lat < 50) begin
      lat++;
      @(negedge clk_i);
    end
    if (!rsp_valid_o) begin
      errors++;
      $display("Timeout: no response for address %h within 50 cycles", a);
    end
    rd = rsp_rdata_o;
    // Write lands on this edge, request dropped here
    @(posedge clk_i);
    req_valid_i <= 1'b0;
  endtask

  // Unmapped address must stay silent for 20 cycles
  task automatic probe_unmapped(input logic [31:0] a);
    @(posedge clk_i);
    req_valid_i <= 1'b1;
    req_addr_i  <= a;
    req_we_i    <= 1'b0;
    for (int n = 0; n < 20; n++) begin
      @(negedge clk_i);
      assert (!rsp_valid_o) else begin
        errors++;
        $display("Unmapped address %h got a response", a);
      end
    end
    @(posedge clk_i);
    req_valid_i <= 1'b0;
  endtask

  task automatic wait_timer_irq();
    int n;
    n = 0;
    @(negedge clk_i);
    while (!timer_irq_o && n < 300) begin
      n++;
      @(negedge clk_i);
    end
    assert (timer_irq_o) else begin
      errors++;
      $display("Timer interrupt did not rise within 300 cycles");
    end
  endtask

  // ==================================================
  // One pattern line
  // ==================================================
  task automatic run_line();
    logic [31:0] rd;
    int          lat;
    int          exp_lat;
    // RAM answers late, everything mapped else at once
    exp_lat = addr[31] ? ram_latency : 0;
    case (op)
      "W": begin
        if (mode == 1) data = $random(seed);
        bus_access(addr, 1'b1, data, strb, rd, lat);
        check_value("response latency", 32'(exp_lat), 32'(lat));
        // Merge strobed bytes into the RAM model
        for (int b = 0; b < 4; b++) begin
          if (addr[31] && strb[b]) ram_sb[addr[11:2]][8*b +: 8] = data[8*b +: 8];
        end
        if (mode == 3) wait_timer_irq();
        if (mode == 2 || mode == 4 || mode == 5) @(negedge clk_i);
        if (mode == 2) check_value("{timer_irq_o,sw_irq_o}", exp, {30'd0, timer_irq_o, sw_irq_o});
        if (mode == 4) check_value("gpio_o", exp, gpio_o);
        if (mode == 5) check_value("gpio_oe_o", exp, gpio_oe_o);
      end
      "R": begin
        bus_access(addr, 1'b0, 32'd0, strb, rd, lat);
        check_value("response latency", 32'(exp_lat), 32'(lat));
        if (mode == 1) check_value("rsp_rdata_o", ram_sb[addr[11:2]], rd);
        if (mode == 0) check_value("rsp_rdata_o", exp, rd);
        if (mode == 6) begin
          // mtime keeps counting
          assert (rd > last_mtime) else begin
            errors++;
            $display("mtime did not increase between two reads");
          end
          last_mtime = rd;
        end
      end
      "G": begin
        @(posedge clk_i);
        gpio_i <= data;
        // Synchronizer plus input register
        repeat (3) @(posedge clk_i);
      end
      "N": probe_unmapped(addr);
      default: begin
        errors++;
        $display("Unknown operation in pattern line: %s", line);
      end
    endcase
  endtask

  initial begin
    rst_ni      = 1'b0;
    req_valid_i = 1'b0;
    req_addr_i  = '0;
    req_we_i    = 1'b0;
    req_wdata_i = '0;
    req_strb_i  = '0;
    gpio_i      = '0;
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    fd = $fopen("ceres_fabric_patterns.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Cannot open the pattern file");
    end else begin
      while (!$feof(fd)) begin
        if ($fgets(line, fd) == 0) break;
        if (line.len() < 2 || line[0] == "#") continue;
        fields = $sscanf(line, "%c %d %h %h %h %h", op, mode, addr, data, strb, exp);
        if (fields != 6) begin
          errors++;
          $display("Malformed pattern line: %s", line);
        end else begin
          run_line();
        end
      end
      $fclose(fd);
    end
    repeat (2) @(posedge clk_i);
    // Concurrent assertion failures from the bound checker
    errors += i_dut.i_props.prop_errors;
    $display("Checks finished with %0d errors", errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: ceres_fabric_patterns.txt
# op mode addr data strb expect  (op W write, R read, G drive gpio_i, N unmapped probe)
# mode 0 plain, 1 random data or RAM model, 2 irq lines, 3 wait timer irq, 4 gpio_o, 5 gpio_oe_o, 6 rising
W 0 80000000 deadbeef f 00000000
W 0 80000004 11223344 f 00000000
W 0 80000004 aabbccdd 6 00000000
R 0 80000000 00000000 f deadbeef
R 0 80000004 00000000 f 11bbcc44
W 1 80000ffc 00000000 f 00000000
W 1 80000400 00000000 f 00000000
R 1 80000ffc 00000000 f 00000000
R 1 80000400 00000000 f 00000000
W 0 30004000 12345678 f 00000000
W 0 30004004 00000001 f 00000000
R 0 30004000 00000000 f 12345678
R 0 30004004 00000000 f 00000001
R 6 3000bff8 00000000 f 00000000
R 6 3000bff8 00000000 f 00000000
W 2 30000000 00000001 f 00000001
W 2 30000000 00000000 f 00000000
W 0 3000bff8 00000000 f 00000000
W 0 30004004 00000000 f 00000000
W 3 30004000 000000c8 f 00000000
W 2 30004000 ffffffff f 00000000
W 4 20004000 aabbccdd f aabbccdd
W 4 20004000 11223344 5 aa22cc44
W 5 20004004 0000ffff f 0000ffff
G 0 00000000 5a5aa5a5 0 00000000
R 0 20004008 00000000 f 5a5aa5a5
R 0 20006000 00000000 f 00000000
N 0 10000000 00000000 f 00000000

// File: ceres_fabric.f
ceres_pkg.sv
ceres_bus_decoder.sv
ceres_ram.sv
ceres_clint.sv
ceres_gpio.sv
ceres_fabric_top.sv
ceres_fabric_properties.sv
tb_ceres_fabric.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the ceres_fabric testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_ceres_fabric -f ceres_fabric.f -o sim_ceres_fabric \
  || { echo "Build failed"; exit 1; }

./obj_dir/sim_ceres_fabric 2>&1 | tee sim.log

grep -q "Regression passed" sim.log && echo "Simulation ok" \
  || { echo "Simulation failed, see sim.log"; exit 1; }
